//--- logic/beacon_pkg.sv
package beacon_pkg;

    //////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////

    // One serial payload byte
    typedef logic [7:0]  byte_t;

    // Clock cycles per serial bit
    typedef logic [15:0] baud_div_t;

    // Idle clock cycles inserted between frames
    typedef logic [15:0] gap_t;

    // Register address
    typedef logic [3:0]  cfg_addr_t;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    // Width of the write data bus
    localparam int CFG_DATA_W = 16;

    // Bit 0 is run
    localparam cfg_addr_t CFG_CTRL = 4'h0;

    // Baud divisor
    localparam cfg_addr_t CFG_DIV  = 4'h1;

    // Gap length in clock cycles
    localparam cfg_addr_t CFG_GAP  = 4'h2;

    // Message length minus one
    localparam cfg_addr_t CFG_LEN  = 4'h3;

    // First message byte, byte i at CFG_MSG0 + i
    localparam cfg_addr_t CFG_MSG0 = 4'h4;

    // Smallest divisor the transmitter runs with
    localparam baud_div_t BAUD_DIV_MIN = 16'd2;

endpackage

//--- logic/beacon_config.sv
`timescale 1ns/100ps

module beacon_config #(
    parameter  int MSG_DEPTH = 4,
    localparam int IDX_W     = $clog2(MSG_DEPTH)
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          cfg_we,
    input  beacon_pkg::cfg_addr_t                         cfg_addr,
    input  logic [beacon_pkg::CFG_DATA_W-1:0]             cfg_wdata,
    output logic                                          run,
    output beacon_pkg::baud_div_t                         baud_div,
    output beacon_pkg::gap_t                              gap,
    output logic [IDX_W-1:0]                              msg_len,
    output logic [MSG_DEPTH*$bits(beacon_pkg::byte_t)-1:0] msg_bytes
);

    import beacon_pkg::*;

    // Message storage, one entry per byte
    byte_t     msg_mem [MSG_DEPTH];

    // Offset of the write address from the first message byte
    cfg_addr_t msg_off;
    logic      msg_hit;

    assign msg_off = cfg_addr - CFG_MSG0;
    assign msg_hit = (cfg_addr >= CFG_MSG0) && (int'(msg_off) < MSG_DEPTH);

    //////////////////////////////////////////////////
    // Control registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run      <= 1'b0;
            baud_div <= BAUD_DIV_MIN;
            gap      <= '0;
            msg_len  <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_CTRL: begin
                    run <= cfg_wdata[0];
                end
                CFG_DIV: begin
                    // Divisors of 0 and 1 run as 2
                    if (cfg_wdata < BAUD_DIV_MIN) begin
                        baud_div <= BAUD_DIV_MIN;
                    end else begin
                        baud_div <= baud_div_t'(cfg_wdata);
                    end
                end
                CFG_GAP: begin
                    gap <= gap_t'(cfg_wdata);
                end
                CFG_LEN: begin
                    // Longest message is the full buffer
                    if (cfg_wdata >= MSG_DEPTH) begin
                        msg_len <= IDX_W'(MSG_DEPTH - 1);
                    end else begin
                        msg_len <= cfg_wdata[IDX_W-1:0];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Message bytes
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cfg_we && msg_hit) begin
            msg_mem[msg_off[IDX_W-1:0]] <= cfg_wdata[$bits(byte_t)-1:0];
        end
    end

    // Flatten for the sequencer, byte 0 in the low bits
    always_comb begin
        for (int i = 0; i < MSG_DEPTH; i++) begin
            msg_bytes[i*$bits(byte_t) +: $bits(byte_t)] = msg_mem[i];
        end
    end

    // A write needs a known address
    a_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_we |-> !$isunknown(cfg_addr)
    );

endmodule

//--- logic/beacon_sequencer.sv
`timescale 1ns/100ps

module beacon_sequencer #(
    parameter  int MSG_DEPTH = 4,
    localparam int IDX_W     = $clog2(MSG_DEPTH)
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          run,
    input  beacon_pkg::gap_t                              gap,
    input  logic [IDX_W-1:0]                              msg_len,
    input  logic [MSG_DEPTH*$bits(beacon_pkg::byte_t)-1:0] msg_bytes,
    input  logic                                          tx_done,
    output logic                                          tx_en,
    output beacon_pkg::byte_t                             tx_data,
    output logic                                          busy
);

    import beacon_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_GAP
    } seq_state_t;

    seq_state_t       state;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] next_idx;
    gap_t             gap_cnt;
    logic             gap_end;
    logic             load;
    logic             run_q;
    logic             run_rise;
    logic             restart;

    assign run_rise = run && !run_q;
    assign gap_end  = (state == ST_GAP) && (gap_cnt >= gap);

    // A new byte is picked when a frame is about to start
    assign load = run && ((state == ST_IDLE) || gap_end);

    // Index wraps after msg_len, restarts after a fresh run
    always_comb begin
        if ((state == ST_IDLE) || restart || run_rise) begin
            next_idx = '0;
        end else if (idx >= msg_len) begin
            next_idx = '0;
        end else begin
            next_idx = idx + 1'b1;
        end
    end

    assign busy = (state != ST_IDLE);

    //////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            tx_en   <= 1'b0;
            idx     <= '0;
            gap_cnt <= '0;
            run_q   <= 1'b0;
            restart <= 1'b0;
        end else begin
            run_q <= run;

            // Remember a run rise seen mid-frame until the next pick
            if (load) begin
                restart <= 1'b0;
            end else if (run_rise) begin
                restart <= 1'b1;
            end

            case (state)
                ST_IDLE: begin
                    if (run) begin
                        idx   <= next_idx;
                        tx_en <= 1'b1;
                        state <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    // Enable holds until the transmitter reports done
                    if (tx_done) begin
                        tx_en   <= 1'b0;
                        gap_cnt <= '0;
                        state   <= ST_GAP;
                    end
                end
                ST_GAP: begin
                    if (gap_end) begin
                        if (run) begin
                            idx   <= next_idx;
                            tx_en <= 1'b1;
                            state <= ST_SEND;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: begin
                    tx_en <= 1'b0;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Byte held steady for the whole frame
    always_ff @(posedge clk) begin
        if (load) begin
            tx_data <= msg_bytes[next_idx*$bits(byte_t) +: $bits(byte_t)];
        end
    end

    a_done_needs_en: assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_done |-> tx_en
    );

    // Picked index never passes the length seen when it was picked
    a_idx_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(tx_en) |-> (idx <= $past(msg_len))
    );

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  tx_en,
    input  beacon_pkg::byte_t     tx_data,
    input  beacon_pkg::baud_div_t baud_div,
    output logic                  txd,
    output logic                  tx_done
);

    import beacon_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } tx_state_t;

    tx_state_t state;
    baud_div_t div_q;
    baud_div_t baud_cnt;
    logic [2:0] bit_cnt;
    byte_t     shift;
    logic      bit_end;
    logic      shift_out;

    // Last cycle of the current bit
    assign bit_end = (baud_cnt == div_q - 1'b1);

    assign tx_done = (state == ST_STOP) && bit_end;

    // Shift after the start bit and after each data bit
    assign shift_out = bit_end && ((state == ST_START) || (state == ST_DATA));

    //////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            txd      <= 1'b1;
            div_q    <= BAUD_DIV_MIN;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    txd      <= 1'b1;
                    baud_cnt <= '0;
                    if (tx_en) begin
                        // Divisor frozen for the whole frame
                        div_q <= baud_div;
                        txd   <= 1'b0;
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        txd      <= shift[0];
                        state    <= ST_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        if (bit_cnt == 3'd7) begin
                            txd   <= 1'b1;
                            state <= ST_STOP;
                        end else begin
                            txd     <= shift[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                ST_STOP: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        state    <= ST_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    txd   <= 1'b1;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // LSB first, next bit always sits in shift[0]
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && tx_en) begin
            shift <= tx_data;
        end else if (shift_out) begin
            shift <= shift >> 1;
        end
    end

    a_done_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_done |=> !tx_done
    );

endmodule

//--- logic/uart_beacon_top.sv
`timescale 1ns/100ps

module uart_beacon_top #(
    parameter int MSG_DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cfg_we,
    input  beacon_pkg::cfg_addr_t             cfg_addr,
    input  logic [beacon_pkg::CFG_DATA_W-1:0] cfg_wdata,
    output logic                              txd,
    output logic                              busy
);

    import beacon_pkg::*;

    localparam int IDX_W = $clog2(MSG_DEPTH);

    //////////////////////////////////////////////////
    // Internal nets
    //////////////////////////////////////////////////

    logic                              run;
    baud_div_t                         baud_div;
    gap_t                              gap;
    logic [IDX_W-1:0]                  msg_len;
    logic [MSG_DEPTH*$bits(byte_t)-1:0] msg_bytes;
    logic                              tx_en;
    byte_t                             tx_data;
    logic                              tx_done;

    beacon_config #(
        .MSG_DEPTH (MSG_DEPTH)
    ) config_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .run       (run),
        .baud_div  (baud_div),
        .gap       (gap),
        .msg_len   (msg_len),
        .msg_bytes (msg_bytes)
    );

    beacon_sequencer #(
        .MSG_DEPTH (MSG_DEPTH)
    ) sequencer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .gap       (gap),
        .msg_len   (msg_len),
        .msg_bytes (msg_bytes),
        .tx_done   (tx_done),
        .tx_en     (tx_en),
        .tx_data   (tx_data),
        .busy      (busy)
    );

    // Serial line driver
    uart_tx tx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_en    (tx_en),
        .tx_data  (tx_data),
        .baud_div (baud_div),
        .txd      (txd),
        .tx_done  (tx_done)
    );

endmodule

//--- verification/uart_beacon_checker.sv
`timescale 1ns/100ps

module uart_beacon_checker #(
    parameter int MSG_DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cfg_we,
    input  beacon_pkg::cfg_addr_t             cfg_addr,
    input  logic [beacon_pkg::CFG_DATA_W-1:0] cfg_wdata,
    input  logic                              txd,
    input  logic                              busy,
    output int                                frame_cnt,
    output int                                tests_passed,
    output int                                tests_failed
);

    import beacon_pkg::*;

    localparam int IDX_W = $clog2(MSG_DEPTH);

    // Register mirror, updated on the same edge as the DUT
    logic  run_m;
    int    div_m;
    int    gap_m;
    int    len_m;
    byte_t msg_m [MSG_DEPTH];

    // Line decoder, sampled on the falling edge
    logic  in_frame;
    logic  have_prev;
    logic  frame_err;
    logic  exp_bit;
    logic  run_d1;
    logic  run_d2;
    logic  busy_d1;
    byte_t exp_byte;
    int    div_f;
    int    bit_pos;
    int    bit_cyc;
    int    idle_cnt;
    int    next_idx;
    int    err_cnt;
    int    test_no;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_m <= 1'b0;
            div_m <= 2;
            gap_m <= 0;
            len_m <= 0;
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_CTRL: run_m <= cfg_wdata[0];
                CFG_DIV:  div_m <= (cfg_wdata < 16'd2) ? 2 : int'(cfg_wdata);
                CFG_GAP:  gap_m <= int'(cfg_wdata);
                CFG_LEN:  len_m <= (int'(cfg_wdata) >= MSG_DEPTH)
                                   ? MSG_DEPTH - 1 : int'(cfg_wdata);
                default: begin
                    if (int'(cfg_addr) >= int'(CFG_MSG0)
                        && int'(cfg_addr) - int'(CFG_MSG0) < MSG_DEPTH) begin
                        msg_m[IDX_W'(int'(cfg_addr) - int'(CFG_MSG0))] <= cfg_wdata[7:0];
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Frame decoder and gap timing
    //////////////////////////////////////////////////

    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_frame     = 1'b0;
            have_prev    = 1'b0;
            run_d1       = 1'b0;
            run_d2       = 1'b0;
            busy_d1      = 1'b0;
            idle_cnt     = 0;
            next_idx     = 0;
            err_cnt      = 0;
            test_no      = 0;
            frame_cnt    = 0;
            tests_passed = 0;
            tests_failed = 0;
        end else begin
            // Fresh run restarts the message at byte 0
            if (run_m && !run_d1) begin
                next_idx  = 0;
                frame_cnt = 0;
                have_prev = 1'b0;
                test_no   = test_no + 1;
            end
            if (busy && !busy_d1 && !run_d1) begin
                $display("test %0d: busy rose while run was clear at %0t", test_no, $time);
                err_cnt = err_cnt + 1;
            end
            if (!in_frame) begin
                if (!txd) begin
                    if (!run_d2) begin
                        $display("test %0d: start bit after run was cleared at %0t",
                                 test_no, $time);
                        err_cnt = err_cnt + 1;
                    end
                    if (have_prev && idle_cnt != gap_m + 2) begin
                        $display("mismatch at %0t: test %0d idle %0d cycles, expected %0d",
                                 $time, test_no, idle_cnt, gap_m + 2);
                        err_cnt = err_cnt + 1;
                    end
                    in_frame  = 1'b1;
                    frame_err = 1'b0;
                    div_f     = div_m;
                    exp_byte  = msg_m[IDX_W'(next_idx)];
                    next_idx  = (next_idx >= len_m) ? 0 : next_idx + 1;
                    bit_pos   = 0;
                    bit_cyc   = 1;
                end else begin
                    idle_cnt = idle_cnt + 1;
                end
            end else begin
                // Start low, data LSB first, stop high
                if (bit_pos == 0) begin
                    exp_bit = 1'b0;
                end else if (bit_pos == 9) begin
                    exp_bit = 1'b1;
                end else begin
                    exp_bit = exp_byte[bit_pos-1];
                end
                if (txd !== exp_bit && !frame_err) begin
                    frame_err = 1'b1;
                    err_cnt   = err_cnt + 1;
                    if (bit_pos == 9) begin
                        $display("test %0d: stop bit of frame %0d was low at %0t",
                                 test_no, frame_cnt, $time);
                    end else begin
                        $display("mismatch at %0t: test %0d frame %0d byte %h bit %0d got %b",
                                 $time, test_no, frame_cnt, exp_byte, bit_pos, txd);
                    end
                end
                bit_cyc = bit_cyc + 1;
            end
            if (in_frame && bit_cyc == div_f) begin
                bit_cyc = 0;
                bit_pos = bit_pos + 1;
                if (bit_pos == 10) begin
                    in_frame  = 1'b0;
                    have_prev = 1'b1;
                    idle_cnt  = 0;
                    frame_cnt = frame_cnt + 1;
                end
            end
            // A test ends when the sequencer goes idle
            if (!busy && busy_d1) begin
                if (idle_cnt != gap_m + 2) begin
                    $display("test %0d: busy fell before the last gap finished", test_no);
                    err_cnt = err_cnt + 1;
                end
                if (err_cnt == 0 && frame_cnt > 0) begin
                    tests_passed = tests_passed + 1;
                end else begin
                    tests_failed = tests_failed + 1;
                end
                $display("test %0d: %0d frames, %0d errors", test_no, frame_cnt, err_cnt);
                err_cnt = 0;
            end
            run_d2  = run_d1;
            run_d1  = run_m;
            busy_d1 = busy;
        end
    end

endmodule

//--- verification/uart_beacon_tb.sv
`timescale 1ns/100ps

module uart_beacon_tb;

    import beacon_pkg::*;

    localparam int MSG_DEPTH = 4;
    localparam int NUM_ROWS  = 4;

    typedef struct packed {
        logic [15:0] div;
        logic [15:0] gap;
        logic [3:0]  len;
        logic [31:0] msg;
        logic [7:0]  frames;
        logic        rnd;
        logic        change;
    } row_t;

    // Divisor, gap, length, bytes 3..0, frames, random bytes, change while running
    row_t rows [NUM_ROWS] = '{
        '{16'd4, 16'd0, 4'd1, 32'h0000_00a5, 8'd3, 1'b0, 1'b0},
        '{16'd0, 16'd3, 4'd3, 32'h0000_0000, 8'd7, 1'b1, 1'b0},
        '{16'd5, 16'd6, 4'd4, 32'h3c81_0ff0, 8'd9, 1'b0, 1'b0},
        '{16'd3, 16'd2, 4'd3, 32'h0000_0000, 8'd6, 1'b1, 1'b1}
    };

    logic                  clk;
    logic                  rst_n;
    logic                  cfg_we;
    cfg_addr_t             cfg_addr;
    logic [CFG_DATA_W-1:0] cfg_wdata;
    logic                  txd;
    logic                  busy;
    int                    frame_cnt;
    int                    tests_passed;
    int                    tests_failed;
    logic [31:0]           lcg_state;
    int                    cycle_cnt = 0;
    int                    cycle_limit;

    uart_beacon_top #(.MSG_DEPTH(MSG_DEPTH)) dut_i (
        .clk(clk), .rst_n(rst_n), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .txd(txd), .busy(busy)
    );

    uart_beacon_checker #(.MSG_DEPTH(MSG_DEPTH)) chk_i (
        .clk(clk), .rst_n(rst_n), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .txd(txd), .busy(busy), .frame_cnt(frame_cnt),
        .tests_passed(tests_passed), .tests_failed(tests_failed)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic byte_t rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // Worst case frames times frame length, plus one trailing frame per row
    function automatic int limit_from_table();
        int total;
        int eff_div;
        total = 400;
        for (int r = 0; r < NUM_ROWS; r++) begin
            eff_div = (rows[r].div < 16'd2) ? 2 : int'(rows[r].div);
            if (rows[r].change) begin
                eff_div = eff_div + 3;
            end
            total = total + 60
                  + (int'(rows[r].frames) + 1) * (10 * eff_div + int'(rows[r].gap) + 2);
        end
        return total;
    endfunction

    task automatic write_reg(input cfg_addr_t addr, input logic [CFG_DATA_W-1:0] data);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        @(posedge clk);
        while (frame_cnt < n) begin
            @(posedge clk);
        end
    endtask

    task automatic run_row(input row_t row);
        byte_t b;
        write_reg(CFG_DIV, row.div);
        write_reg(CFG_GAP, row.gap);
        write_reg(CFG_LEN, 16'(row.len - 4'd1));
        for (int i = 0; i < MSG_DEPTH; i++) begin
            b = row.rnd ? rand_byte() : 8'(row.msg >> (8 * i));
            write_reg(cfg_addr_t'(int'(CFG_MSG0) + i), {8'h00, b});
        end
        write_reg(CFG_CTRL, 16'h0001);
        if (row.change) begin
            // New divisor and a new byte 1 while byte 1 is on the line
            wait_frames(1);
            @(negedge clk);
            while (txd) begin
                @(negedge clk);
            end
            write_reg(CFG_DIV, row.div + 16'd3);
            write_reg(cfg_addr_t'(int'(CFG_MSG0) + 1), {8'h00, rand_byte()});
        end
        wait_frames(int'(row.frames));
        write_reg(CFG_CTRL, 16'h0000);
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: no result after %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        cfg_we      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        lcg_state   = 32'hf9be9332;
        cycle_limit = limit_from_table();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        // Line stays idle while run is 0
        repeat (10) @(negedge clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        repeat (3) @(negedge clk);
        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && tests_passed == NUM_ROWS) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
logic/beacon_pkg.sv
logic/beacon_config.sv
logic/beacon_sequencer.sv
logic/uart_tx.sv
logic/uart_beacon_top.sv
verification/uart_beacon_checker.sv
verification/uart_beacon_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= uart_beacon_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
